/* logic/cluster_types_pkg.sv */
package cluster_types_pkg;

  // tag space of the reorder buffer outside the cluster
  localparam int ROB_SIZE = 8;
  localparam int ROB_TAG_W = $clog2(ROB_SIZE);

  localparam int WORD_W = 32;

  // sizes used when the top level is not overridden
  localparam int RS_DEPTH_DEFAULT = 3;
  localparam int ALU_QUEUE_DEPTH_DEFAULT = 2;

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;   // reorder-buffer entry number
  typedef logic [WORD_W-1:0] word_t;         // data value

endpackage

/* logic/alu_ops_pkg.sv */
package alu_ops_pkg;

  import cluster_types_pkg::*;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_slt  = 4'd5,
    op_sltu = 4'd6,
    op_sll  = 4'd7,
    op_srl  = 4'd8,
    op_sra  = 4'd9
  } alu_op_t;

  // result of one integer operation, shared by the ALU and its model
  function automatic word_t alu_eval(alu_op_t op, word_t a, word_t b);
    word_t res;
    logic [4:0] shamt;
    shamt = b[4:0];   // shifts only look at the low five bits
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_slt:  res = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      op_sltu: res = (a < b) ? word_t'(1) : '0;
      op_sll:  res = a << shamt;
      op_srl:  res = a >> shamt;
      op_sra:  res = word_t'($signed(a) >>> shamt);
      default: res = '0;   // codes 10..15 are never dispatched
    endcase
    return res;
  endfunction

endpackage

/* logic/dispatch_if.sv */
interface dispatch_if;

  import cluster_types_pkg::*;
  import alu_ops_pkg::*;

  logic     valid;
  alu_op_t  op;
  rob_tag_t tag;        // destination tag
  logic     i_ready;    // operand i holds a value, else waits on i_tag
  rob_tag_t i_tag;
  word_t    i_value;
  logic     j_ready;
  rob_tag_t j_tag;
  word_t    j_value;
  logic     credit_return;   // one entry freed

  modport cluster (
    output valid, op, tag,
    output i_ready, i_tag, i_value,
    output j_ready, j_tag, j_value,
    input  credit_return
  );

  modport station (
    input  valid, op, tag,
    input  i_ready, i_tag, i_value,
    input  j_ready, j_tag, j_value,
    output credit_return
  );

endinterface

/* logic/cdb_if.sv */
interface cdb_if;

  import cluster_types_pkg::*;

  // one broadcast per cycle on the common data bus
  logic     valid;
  rob_tag_t tag;
  word_t    value;

  modport source (
    output valid,
    output tag,
    output value
  );

  modport listener (
    input valid,
    input tag,
    input value
  );

endinterface

/* logic/reservation_station.sv */
module reservation_station #(
  parameter int RS_DEPTH = cluster_types_pkg::RS_DEPTH_DEFAULT,
  parameter int ALU_QUEUE_DEPTH = cluster_types_pkg::ALU_QUEUE_DEPTH_DEFAULT
) (
  input  logic                        clk_in,
  input  logic                        rst_in,
  dispatch_if.station                 disp,
  cdb_if.listener                     cdb,
  input  logic                        alu_credit,
  output logic                        issue_valid,
  output alu_ops_pkg::alu_op_t        issue_op,
  output cluster_types_pkg::word_t    issue_a,
  output cluster_types_pkg::word_t    issue_b,
  output cluster_types_pkg::rob_tag_t issue_tag
);

  import cluster_types_pkg::*;
  import alu_ops_pkg::*;

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam int CREDIT_W = $clog2(ALU_QUEUE_DEPTH + 1);

  // entry storage
  logic [RS_DEPTH-1:0] busy;
  alu_op_t             op_q [RS_DEPTH];
  rob_tag_t            dest_q [RS_DEPTH];
  logic [RS_DEPTH-1:0] i_rdy;
  rob_tag_t            i_tag_q [RS_DEPTH];
  word_t               i_val_q [RS_DEPTH];
  logic [RS_DEPTH-1:0] j_rdy;
  rob_tag_t            j_tag_q [RS_DEPTH];
  word_t               j_val_q [RS_DEPTH];

  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    sel_idx;
  logic                sel_found;
  logic [RS_DEPTH-1:0] eligible;
  logic                issue_fire;
  logic [CREDIT_W-1:0] alu_credits;   // free result-queue slots

  // dispatch operands after a same-cycle CDB match
  logic  new_i_rdy;
  word_t new_i_val;
  logic  new_j_rdy;
  word_t new_j_val;

  // lowest free entry, the dispatch credits promise one exists
  always_comb begin
    free_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) free_idx = IDX_W'(i);
    end
  end

  assign eligible = busy & i_rdy & j_rdy;

  always_comb begin
    sel_idx = '0;
    sel_found = 1'b0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin   // lowest index wins
      if (eligible[i]) begin
        sel_idx = IDX_W'(i);
        sel_found = 1'b1;
      end
    end
  end

  assign issue_fire = sel_found && (alu_credits != '0);

  always_comb begin
    new_i_rdy = disp.i_ready;
    new_i_val = disp.i_value;
    new_j_rdy = disp.j_ready;
    new_j_val = disp.j_value;
    if (cdb.valid && !disp.i_ready && (cdb.tag == disp.i_tag)) begin
      new_i_rdy = 1'b1;
      new_i_val = cdb.value;
    end
    if (cdb.valid && !disp.j_ready && (cdb.tag == disp.j_tag)) begin
      new_j_rdy = 1'b1;
      new_j_val = cdb.value;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
      issue_valid <= 1'b0;
      disp.credit_return <= 1'b0;
      alu_credits <= CREDIT_W'(ALU_QUEUE_DEPTH);
    end else begin
      issue_valid <= issue_fire;
      disp.credit_return <= issue_fire;   // pulse lines up with issue_valid
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (disp.valid && (free_idx == IDX_W'(i))) begin
          busy[i] <= 1'b1;
        end else if (issue_fire && (sel_idx == IDX_W'(i))) begin
          busy[i] <= 1'b0;
        end
      end
      alu_credits <= alu_credits - CREDIT_W'(issue_fire) + CREDIT_W'(alu_credit);
    end
  end

  // entry fields and wakeup, busy decides whether they mean anything
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (disp.valid && (free_idx == IDX_W'(i))) begin
        op_q[i]    <= disp.op;
        dest_q[i]  <= disp.tag;
        i_rdy[i]   <= new_i_rdy;
        i_tag_q[i] <= disp.i_tag;
        i_val_q[i] <= new_i_val;
        j_rdy[i]   <= new_j_rdy;
        j_tag_q[i] <= disp.j_tag;
        j_val_q[i] <= new_j_val;
      end else if (busy[i] && cdb.valid) begin
        if (!i_rdy[i] && (i_tag_q[i] == cdb.tag)) begin
          i_rdy[i]   <= 1'b1;
          i_val_q[i] <= cdb.value;
        end
        if (!j_rdy[i] && (j_tag_q[i] == cdb.tag)) begin
          j_rdy[i]   <= 1'b1;
          j_val_q[i] <= cdb.value;
        end
      end
    end
    if (issue_fire) begin
      issue_op  <= op_q[sel_idx];
      issue_a   <= i_val_q[sel_idx];
      issue_b   <= j_val_q[sel_idx];
      issue_tag <= dest_q[sel_idx];
    end
  end

endmodule

/* logic/alu_unit.sv */
module alu_unit #(
  parameter int ALU_QUEUE_DEPTH = cluster_types_pkg::ALU_QUEUE_DEPTH_DEFAULT
) (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        issue_valid,
  input  alu_ops_pkg::alu_op_t        issue_op,
  input  cluster_types_pkg::word_t    issue_a,
  input  cluster_types_pkg::word_t    issue_b,
  input  cluster_types_pkg::rob_tag_t issue_tag,
  input  logic                        pop,
  output logic                        head_valid,
  output cluster_types_pkg::rob_tag_t head_tag,
  output cluster_types_pkg::word_t    head_value
);

  import cluster_types_pkg::*;
  import alu_ops_pkg::*;

  localparam int PTR_W = (ALU_QUEUE_DEPTH > 1) ? $clog2(ALU_QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(ALU_QUEUE_DEPTH + 1);

  // stage 1 holds the operands of one issue
  logic     s1_valid;
  alu_op_t  s1_op;
  word_t    s1_a;
  word_t    s1_b;
  rob_tag_t s1_tag;

  // stage 2 is the write into the result queue
  rob_tag_t         q_tag [ALU_QUEUE_DEPTH];
  word_t            q_value [ALU_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(ALU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;   // no stall, every issue is taken
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue_valid) begin
      s1_op  <= issue_op;
      s1_a   <= issue_a;
      s1_b   <= issue_b;
      s1_tag <= issue_tag;
    end
  end

  // room is guaranteed by the station's queue credits
  always_ff @(posedge clk_in) begin
    if (s1_valid) begin
      q_tag[wr_ptr]   <= s1_tag;
      q_value[wr_ptr] <= alu_eval(s1_op, s1_a, s1_b);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (s1_valid) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      count <= count + CNT_W'(s1_valid) - CNT_W'(pop);
    end
  end

  assign head_valid = (count != '0);
  assign head_tag   = q_tag[rd_ptr];
  assign head_value = q_value[rd_ptr];

endmodule

/* logic/cdb_arbiter.sv */
module cdb_arbiter #(
  parameter int ALU_QUEUE_DEPTH = cluster_types_pkg::ALU_QUEUE_DEPTH_DEFAULT
) (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        head_valid,
  input  cluster_types_pkg::rob_tag_t head_tag,
  input  cluster_types_pkg::word_t    head_value,
  input  logic                        ext_valid,
  input  cluster_types_pkg::rob_tag_t ext_tag,
  input  cluster_types_pkg::word_t    ext_value,
  output logic                        pop,
  output logic                        ext_ready,
  output logic                        alu_credit,
  cdb_if.source                       cdb
);

  logic ext_take;

  // queue head always wins, external results fill the idle cycles
  assign pop       = head_valid;
  assign ext_ready = ext_valid && !head_valid;
  assign ext_take  = ext_valid && ext_ready;

  assign alu_credit = pop;   // the freed queue slot goes back to the station

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= pop || ext_take;
    end
  end

  always_ff @(posedge clk_in) begin
    if (pop) begin
      cdb.tag   <= head_tag;
      cdb.value <= head_value;
    end else if (ext_take) begin
      cdb.tag   <= ext_tag;
      cdb.value <= ext_value;
    end
  end

endmodule

/* logic/exec_cluster.sv */
module exec_cluster #(
  parameter int RS_DEPTH = cluster_types_pkg::RS_DEPTH_DEFAULT,
  parameter int ALU_QUEUE_DEPTH = cluster_types_pkg::ALU_QUEUE_DEPTH_DEFAULT
) (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        disp_valid,
  input  alu_ops_pkg::alu_op_t        disp_op,
  input  cluster_types_pkg::rob_tag_t disp_tag,
  input  logic                        disp_i_ready,
  input  cluster_types_pkg::rob_tag_t disp_i_tag,
  input  cluster_types_pkg::word_t    disp_i_value,
  input  logic                        disp_j_ready,
  input  cluster_types_pkg::rob_tag_t disp_j_tag,
  input  cluster_types_pkg::word_t    disp_j_value,
  output logic                        disp_credit,
  input  logic                        ext_valid,
  input  cluster_types_pkg::rob_tag_t ext_tag,
  input  cluster_types_pkg::word_t    ext_value,
  output logic                        ext_ready,
  output logic                        cdb_valid,
  output cluster_types_pkg::rob_tag_t cdb_tag,
  output cluster_types_pkg::word_t    cdb_value
);

  import cluster_types_pkg::*;
  import alu_ops_pkg::*;

  dispatch_if disp ();
  cdb_if      cdb ();

  // station to ALU
  logic     issue_valid;
  alu_op_t  issue_op;
  word_t    issue_a;
  word_t    issue_b;
  rob_tag_t issue_tag;

  // ALU queue head and the arbiter's replies
  logic     head_valid;
  rob_tag_t head_tag;
  word_t    head_value;
  logic     pop;
  logic     alu_credit;

  assign disp.valid   = disp_valid;
  assign disp.op      = disp_op;
  assign disp.tag     = disp_tag;
  assign disp.i_ready = disp_i_ready;
  assign disp.i_tag   = disp_i_tag;
  assign disp.i_value = disp_i_value;
  assign disp.j_ready = disp_j_ready;
  assign disp.j_tag   = disp_j_tag;
  assign disp.j_value = disp_j_value;
  assign disp_credit  = disp.credit_return;

  // broadcast leaves for the reorder buffer
  assign cdb_valid = cdb.valid;
  assign cdb_tag   = cdb.tag;
  assign cdb_value = cdb.value;

  reservation_station #(
    .RS_DEPTH        (RS_DEPTH),
    .ALU_QUEUE_DEPTH (ALU_QUEUE_DEPTH)
  ) u_station (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .disp        (disp.station),
    .cdb         (cdb.listener),
    .alu_credit  (alu_credit),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag)
  );

  alu_unit #(
    .ALU_QUEUE_DEPTH (ALU_QUEUE_DEPTH)
  ) u_alu (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .pop         (pop),
    .head_valid  (head_valid),
    .head_tag    (head_tag),
    .head_value  (head_value)
  );

  cdb_arbiter #(
    .ALU_QUEUE_DEPTH (ALU_QUEUE_DEPTH)
  ) u_arbiter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .head_valid (head_valid),
    .head_tag   (head_tag),
    .head_value (head_value),
    .ext_valid  (ext_valid),
    .ext_tag    (ext_tag),
    .ext_value  (ext_value),
    .pop        (pop),
    .ext_ready  (ext_ready),
    .alu_credit (alu_credit),
    .cdb        (cdb.source)
  );

endmodule

/* verif/exec_cluster_tb.sv */
module exec_cluster_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_types_pkg::*;
  import alu_ops_pkg::*;

  localparam int RS_DEPTH = 3;
  localparam int ALU_QUEUE_DEPTH = 2;
  localparam int N_DISPATCH = 400;
  localparam int CYCLE_LIMIT = N_DISPATCH * 20;

  logic     clk_in = 1'b0;
  logic     rst_in = 1'b1;
  logic     disp_valid = 1'b0;
  logic     disp_i_ready = 1'b0;
  logic     disp_j_ready = 1'b0;
  logic     ext_valid = 1'b0;
  alu_op_t  disp_op = op_add;
  rob_tag_t disp_tag = '0;
  rob_tag_t disp_i_tag = '0;
  rob_tag_t disp_j_tag = '0;
  rob_tag_t ext_tag = '0;
  word_t    disp_i_value = '0;
  word_t    disp_j_value = '0;
  word_t    ext_value = '0;
  logic     disp_credit, ext_ready, cdb_valid;   // DUT outputs
  rob_tag_t cdb_tag;
  word_t    cdb_value;

  // reference model, indexed by tag, operand 0 is i and 1 is j
  bit       outstanding [ROB_SIZE];
  bit       from_alu [ROB_SIZE];
  bit       ext_taken [ROB_SIZE];   // handshake done, broadcast may follow
  word_t    ext_val [ROB_SIZE];
  alu_op_t  m_op [ROB_SIZE];
  bit       m_rdy [ROB_SIZE][2];
  rob_tag_t m_src [ROB_SIZE][2];
  word_t    m_val [ROB_SIZE][2];
  rob_tag_t ext_queue [$];          // external results waiting for the port
  int       credits = RS_DEPTH;
  int       n_disp = 0;
  int       n_returned = 0;
  int       cycles = 0;
  bit       any_request = 1'b0;

  exec_cluster #(
    .RS_DEPTH        (RS_DEPTH),
    .ALU_QUEUE_DEPTH (ALU_QUEUE_DEPTH)
  ) uut (.*);

  always #10 clk_in = ~clk_in;

  task automatic stop_on_error(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  function automatic word_t expected_result(alu_op_t op, word_t a, word_t b);
    int unsigned sh;
    sh = b % 32;
    case (op)
      op_add:  return a + b;
      op_sub:  return a + ~b + 1;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_slt:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);   // signs differ
      op_sltu: return word_t'(a < b);
      op_sll:  return a << sh;
      op_srl:  return a >> sh;
      op_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      default: return '0;
    endcase
  endfunction

  function automatic int outstanding_count();
    int n;
    n = 0;
    foreach (outstanding[t]) n += outstanding[t];
    return n;
  endfunction

  // either a value or a wait on a tag that has not been broadcast yet
  task automatic pick_operand(output logic rdy, output rob_tag_t src, output word_t val);
    rob_tag_t cands [$];
    foreach (outstanding[t]) begin
      if (outstanding[t]) cands.push_back(rob_tag_t'(t));
    end
    rdy = 1'b1;
    src = rob_tag_t'($urandom);
    val = $urandom;
    if (cands.size() != 0 && $urandom_range(0, 1) == 1) begin
      rdy = 1'b0;
      src = cands[$urandom_range(0, cands.size() - 1)];
    end
  endtask

  task automatic check_broadcast(input rob_tag_t tag, input word_t value);
    word_t expv;
    assert (outstanding[tag]) else stop_on_error($sformatf("tag %0d broadcast twice", tag));
    if (from_alu[tag]) begin
      assert (m_rdy[tag][0] && m_rdy[tag][1])
        else stop_on_error($sformatf("tag %0d broadcast before its operands", tag));
      expv = expected_result(m_op[tag], m_val[tag][0], m_val[tag][1]);
    end else begin
      assert (ext_taken[tag])
        else stop_on_error($sformatf("external tag %0d broadcast without handshake", tag));
      expv = ext_val[tag];
    end
    assert (value == expv)
      else stop_on_error($sformatf("tag %0d value %h, expected %h", tag, value, expv));
    outstanding[tag] = 1'b0;
    foreach (outstanding[t]) begin   // wakeup, also for a dispatch taken at this edge
      for (int k = 0; k < 2; k++) begin
        if (outstanding[t] && from_alu[t] && !m_rdy[t][k] && m_src[t][k] == tag) begin
          m_rdy[t][k] = 1'b1;
          m_val[t][k] = value;
        end
      end
    end
  endtask

  task automatic sample_edge();
    if (cdb_valid) check_broadcast(cdb_tag, cdb_value);
    if (ext_valid && ext_ready) begin
      ext_taken[ext_queue[0]] = 1'b1;
      void'(ext_queue.pop_front());
    end
    if (disp_credit) begin
      n_returned++;
      credits++;
      assert (n_returned <= n_disp) else stop_on_error("more credits returned than dispatches");
    end
  endtask

  task automatic drive_inputs();
    rob_tag_t free_tags [$];
    rob_tag_t tag;
    int idx;
    bit burst;
    foreach (outstanding[t]) begin
      if (!outstanding[t]) free_tags.push_back(rob_tag_t'(t));
    end
    burst = ((n_disp / 50) % 2) == 1;   // back to back dispatch in every other block
    disp_valid = 1'b0;
    if (n_disp < N_DISPATCH && free_tags.size() >= 3 && ext_queue.size() < 2
        && $urandom_range(0, burst ? 1 : 3) == 0) begin
      idx = $urandom_range(0, free_tags.size() - 1);
      tag = free_tags[idx];
      free_tags.delete(idx);
      outstanding[tag] = 1'b1;
      from_alu[tag] = 1'b0;
      ext_taken[tag] = 1'b0;
      ext_val[tag] = $urandom;
      ext_queue.push_back(tag);
    end
    if (n_disp < N_DISPATCH && credits > 0 && free_tags.size() != 0
        && (burst || $urandom_range(0, 2) != 0)) begin
      pick_operand(disp_i_ready, disp_i_tag, disp_i_value);
      pick_operand(disp_j_ready, disp_j_tag, disp_j_value);
      disp_tag = free_tags[$urandom_range(0, free_tags.size() - 1)];
      disp_op = alu_op_t'($urandom_range(0, 9));
      disp_valid = 1'b1;
      outstanding[disp_tag] = 1'b1;
      from_alu[disp_tag] = 1'b1;
      m_op[disp_tag] = disp_op;
      m_rdy[disp_tag] = '{disp_i_ready, disp_j_ready};
      m_src[disp_tag] = '{disp_i_tag, disp_j_tag};
      m_val[disp_tag] = '{disp_i_value, disp_j_value};
      credits--;
      n_disp++;
    end
    ext_valid = (ext_queue.size() != 0);   // held until accepted
    if (ext_valid) begin
      ext_tag = ext_queue[0];
      ext_value = ext_val[ext_queue[0]];
    end
    if (disp_valid || ext_valid) any_request = 1'b1;
  endtask

  assert property (@(posedge clk_in) disable iff (rst_in)
    !any_request |-> !cdb_valid && !disp_credit && !ext_ready)
    else stop_on_error("outputs active before any dispatch or external request");
  // an accepted external result is the very next broadcast
  assert property (@(posedge clk_in) disable iff (rst_in)
    ext_valid && ext_ready |=> cdb_valid && cdb_tag == $past(ext_tag)
      && cdb_value == $past(ext_value))
    else stop_on_error("accepted external result not broadcast in the next cycle");
  assert property (@(posedge clk_in) disable iff (rst_in)
    ext_valid && !ext_ready |=> ext_valid && $stable(ext_tag) && $stable(ext_value))
    else stop_on_error("external result dropped or changed before acceptance");

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: %0d tags still outstanding after %0d cycles",
               outstanding_count(), cycles);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(32'hd7058511));
    repeat (8) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    while (n_disp < N_DISPATCH || outstanding_count() != 0) begin
      @(posedge clk_in);
      sample_edge();
      @(negedge clk_in);
      drive_inputs();
    end
    // issue returns the credit before its broadcast, so the count is complete here
    if (credits == RS_DEPTH && n_returned == n_disp) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d credits held, %0d of %0d returned after draining",
                              credits, n_returned, n_disp));
    end
  end

endmodule

/* exec_cluster.f */
logic/cluster_types_pkg.sv
logic/alu_ops_pkg.sv
logic/dispatch_if.sv
logic/cdb_if.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
verif/exec_cluster_tb.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - logic/cluster_types_pkg.sv
  - logic/alu_ops_pkg.sv
  - logic/dispatch_if.sv
  - logic/cdb_if.sv
  - logic/reservation_station.sv
  - logic/alu_unit.sv
  - logic/cdb_arbiter.sv
  - logic/exec_cluster.sv
  - target: simulation
    files:
      - verif/exec_cluster_tb.sv
